// File: verilog/lrelu_settings.svh
`ifndef LRELU_SETTINGS_SVH
`define LRELU_SETTINGS_SVH

// lanes and word widths
`define LRELU_UNITS    8
`define LRELU_IN_W     32  // accumulator word
`define LRELU_OUT_W    8   // requantised word
`define LRELU_MID_W    40  // scaled value between the two compute stages

// config stream and coefficients
`define COEF_W         16
`define COEF_FRAC      12  // a is Q3.12

// leaky relu slope, 26/256 ~ 0.1
`define LRELU_ALPHA    26
`define ALPHA_FRAC     8

// table entries per mode
`define DEPTH_1X1      6
`define DEPTH_3X3      2

// enabled cycles from s_beat to m_beat
`define LRELU_LATENCY  4

`endif

// File: verilog/lrelu_pkg.sv
`include "lrelu_settings.svh"

package lrelu_pkg;

  typedef logic signed [`LRELU_IN_W-1:0]  in_word_t;
  typedef logic signed [`LRELU_MID_W-1:0] mid_word_t;
  typedef logic signed [`LRELU_OUT_W-1:0] out_word_t;

  typedef logic [2:0] tbl_addr_t;  // covers both table depths

  // which coefficient the next config word belongs to
  typedef enum logic [1:0] {SEL_D, SEL_A, SEL_B} load_sel_e;

  typedef struct packed {
    logic is_lrelu;
    logic is_max;   // carried through for the max-pool stage
  } beat_user_t;

  typedef struct packed {
    logic                           valid;
    beat_user_t                     user;
    in_word_t [`LRELU_UNITS-1:0]    data;
  } in_beat_t;

  typedef struct packed {
    logic                           valid;
    beat_user_t                     user;
    mid_word_t [`LRELU_UNITS-1:0]   data;
  } mid_beat_t;

  typedef struct packed {
    logic                           valid;
    logic                           is_max;
    out_word_t [`LRELU_UNITS-1:0]   data;
  } out_beat_t;

  typedef struct packed {
    logic              valid;
    logic              is_1x1;
    logic [`COEF_W-1:0] data;
  } cfg_beat_t;

endpackage

// File: verilog/cyclic_table.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module cyclic_table #(
  parameter int DEPTH = `DEPTH_1X1
) (
  input  logic                       clk,
  input  logic                       clken,
  input  logic                       reset,
  input  logic                       we,
  input  logic                       rd_en,
  input  logic                       restart,
  input  lrelu_pkg::tbl_addr_t       w_addr,
  input  lrelu_pkg::tbl_addr_t       rd_last,
  input  logic [`COEF_W-1:0]         w_data,
  output logic signed [`COEF_W-1:0]  rd_data
);

  logic signed [`COEF_W-1:0] mem [DEPTH];
  lrelu_pkg::tbl_addr_t      ptr;  // next entry to read

  // write side, loader keeps w_addr below DEPTH
  always_ff @(posedge clk) begin
    if (clken && we) begin
      mem[w_addr] <= w_data;
    end
  end

  // read pointer walks 0..rd_last and wraps
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (clken) begin
      if (restart) begin
        ptr <= '0;  // new d word, start over
      end else if (rd_en) begin
        ptr <= (ptr == rd_last) ? '0 : ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken && rd_en) begin
      rd_data <= mem[ptr];
    end
  end

endmodule

// File: verilog/coef_loader.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module coef_loader (
  input  logic                       clk,
  input  logic                       clken,
  input  logic                       reset,
  input  lrelu_pkg::cfg_beat_t       cfg,
  output logic                       a_we,
  output logic                       b_we,
  output logic                       restart,
  output lrelu_pkg::tbl_addr_t       w_addr,
  output lrelu_pkg::tbl_addr_t       rd_last,
  output logic [`COEF_W-1:0]         w_data,
  output logic signed [`COEF_W-1:0]  d_val
);

  lrelu_pkg::load_sel_e  sel, sel_next;
  lrelu_pkg::tbl_addr_t  addr, addr_next;
  logic                  is_1x1;  // 0 selects 3x3
  logic                  accept;

  assign accept = clken && cfg.valid;

  // last index also bounds the write count
  assign rd_last = is_1x1 ? lrelu_pkg::tbl_addr_t'(`DEPTH_1X1 - 1)
                          : lrelu_pkg::tbl_addr_t'(`DEPTH_3X3 - 1);

  always_comb begin
    sel_next  = sel;
    addr_next = addr;
    unique case (sel)
      lrelu_pkg::SEL_D: begin
        sel_next  = lrelu_pkg::SEL_A;
        addr_next = '0;
      end
      lrelu_pkg::SEL_A: begin
        if (addr == rd_last) begin
          sel_next  = lrelu_pkg::SEL_B;
          addr_next = '0;
        end else begin
          addr_next = addr + 1'b1;
        end
      end
      lrelu_pkg::SEL_B: begin
        if (addr == rd_last) begin
          sel_next  = lrelu_pkg::SEL_D;  // table set complete
          addr_next = '0;
        end else begin
          addr_next = addr + 1'b1;
        end
      end
      default: begin
        sel_next  = lrelu_pkg::SEL_D;
        addr_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sel    <= lrelu_pkg::SEL_D;
      addr   <= '0;
      is_1x1 <= 1'b0;
      d_val  <= '0;
    end else if (accept) begin
      sel  <= sel_next;
      addr <= addr_next;
      if (sel == lrelu_pkg::SEL_D) begin
        d_val  <= $signed(cfg.data);
        is_1x1 <= cfg.is_1x1;  // mode for the tables that follow
      end
    end
  end

  assign a_we    = accept && (sel == lrelu_pkg::SEL_A);
  assign b_we    = accept && (sel == lrelu_pkg::SEL_B);
  assign restart = accept && (sel == lrelu_pkg::SEL_D);
  assign w_addr  = addr;
  assign w_data  = cfg.data;

endmodule

// File: verilog/affine_stage.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module affine_stage (
  input  logic                       clk,
  input  logic                       clken,
  input  logic                       reset,
  input  lrelu_pkg::in_beat_t        s_beat,
  input  logic signed [`COEF_W-1:0]  a_val,
  input  logic signed [`COEF_W-1:0]  b_val,
  output lrelu_pkg::mid_beat_t       mid
);

  localparam int UNITS  = `LRELU_UNITS;
  localparam int PROD_W = `LRELU_IN_W + `COEF_W;
  localparam int MID_W  = `LRELU_MID_W;

  // first cycle, beat waits here while the tables read
  logic                                    in_valid;
  lrelu_pkg::beat_user_t                   in_user;
  lrelu_pkg::in_word_t  [UNITS-1:0]        in_data;

  // second cycle, scaled values
  logic                                    mid_valid;
  lrelu_pkg::beat_user_t                   mid_user;
  lrelu_pkg::mid_word_t [UNITS-1:0]        mid_data;
  lrelu_pkg::mid_word_t [UNITS-1:0]        scaled;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_valid  <= 1'b0;
      mid_valid <= 1'b0;
    end else if (clken) begin
      in_valid  <= s_beat.valid;
      mid_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      in_user  <= s_beat.user;
      in_data  <= s_beat.data;
      mid_user <= in_user;
      mid_data <= scaled;
    end
  end

  // p = (x*a >>> 12) + b, fits 40 bits
  for (genvar i = 0; i < UNITS; i++) begin : g_lane
    logic signed [PROD_W-1:0] prod;

    assign prod      = $signed(in_data[i]) * a_val;
    assign scaled[i] = MID_W'(prod >>> `COEF_FRAC) + MID_W'(b_val);
  end

  assign mid = '{valid: mid_valid, user: mid_user, data: mid_data};

endmodule

// File: verilog/lrelu_stage.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module lrelu_stage (
  input  logic                       clk,
  input  logic                       clken,
  input  logic                       reset,
  input  lrelu_pkg::mid_beat_t       mid,
  input  logic signed [`COEF_W-1:0]  d_val,
  output lrelu_pkg::out_beat_t       m_beat
);

  localparam int UNITS   = `LRELU_UNITS;
  localparam int MID_W   = `LRELU_MID_W;
  localparam int OUT_MAX = 2 ** (`LRELU_OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (`LRELU_OUT_W - 1));

  logic                                  slope_valid;
  logic                                  slope_max;
  lrelu_pkg::mid_word_t [UNITS-1:0]      slope_data;
  lrelu_pkg::mid_word_t [UNITS-1:0]      q;

  logic                                  out_valid;
  logic                                  out_max;
  lrelu_pkg::out_word_t [UNITS-1:0]      out_data;
  lrelu_pkg::out_word_t [UNITS-1:0]      sat;

  function automatic lrelu_pkg::out_word_t saturate(input logic signed [MID_W:0] v);
    if (v > OUT_MAX) return lrelu_pkg::out_word_t'(OUT_MAX);
    if (v < OUT_MIN) return lrelu_pkg::out_word_t'(OUT_MIN);
    return v[`LRELU_OUT_W-1:0];
  endfunction

  for (genvar i = 0; i < UNITS; i++) begin : g_lane
    logic signed [MID_W+5:0] prod;  // p * 26
    logic signed [MID_W:0]   sum;

    assign prod = $signed(mid.data[i]) * `LRELU_ALPHA;
    // slope only for negative lanes of an lrelu beat
    assign q[i] = (mid.user.is_lrelu && mid.data[i][MID_W-1])
                ? MID_W'(prod >>> `ALPHA_FRAC) : mid.data[i];

    assign sum    = $signed(slope_data[i]) + d_val;  // r = q + d
    assign sat[i] = saturate(sum);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slope_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else if (clken) begin
      slope_valid <= mid.valid;
      out_valid   <= slope_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      slope_max  <= mid.user.is_max;
      slope_data <= q;
      out_max    <= slope_max;
      out_data   <= sat;
    end
  end

  assign m_beat = '{valid: out_valid, is_max: out_max, data: out_data};

endmodule

// File: verilog/lrelu_engine.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module lrelu_engine (
  input  logic                   clk,
  input  logic                   clken,
  input  logic                   reset,
  input  lrelu_pkg::cfg_beat_t   cfg,
  input  lrelu_pkg::in_beat_t    s_beat,
  output lrelu_pkg::out_beat_t   m_beat
);

  // loader to tables
  logic                       a_we;
  logic                       b_we;
  logic                       restart;
  lrelu_pkg::tbl_addr_t       w_addr;
  lrelu_pkg::tbl_addr_t       rd_last;
  logic [`COEF_W-1:0]         w_data;
  logic signed [`COEF_W-1:0]  d_val;

  // tables to scale stage
  logic signed [`COEF_W-1:0]  a_val;
  logic signed [`COEF_W-1:0]  b_val;

  lrelu_pkg::mid_beat_t       mid;

  coef_loader LOADER (
    .clk     (clk),
    .clken   (clken),
    .reset   (reset),
    .cfg     (cfg),
    .a_we    (a_we),
    .b_we    (b_we),
    .restart (restart),
    .w_addr  (w_addr),
    .rd_last (rd_last),
    .w_data  (w_data),
    .d_val   (d_val)
  );

  cyclic_table #(.DEPTH(`DEPTH_1X1)) TABLE_A (
    .clk     (clk),
    .clken   (clken),
    .reset   (reset),
    .we      (a_we),
    .rd_en   (s_beat.valid),  // one entry per beat
    .restart (restart),
    .w_addr  (w_addr),
    .rd_last (rd_last),
    .w_data  (w_data),
    .rd_data (a_val)
  );

  cyclic_table #(.DEPTH(`DEPTH_1X1)) TABLE_B (
    .clk     (clk),
    .clken   (clken),
    .reset   (reset),
    .we      (b_we),
    .rd_en   (s_beat.valid),
    .restart (restart),
    .w_addr  (w_addr),
    .rd_last (rd_last),
    .w_data  (w_data),
    .rd_data (b_val)
  );

  affine_stage AFFINE (
    .clk    (clk),
    .clken  (clken),
    .reset  (reset),
    .s_beat (s_beat),
    .a_val  (a_val),
    .b_val  (b_val),
    .mid    (mid)
  );

  lrelu_stage ACTIVATE (
    .clk    (clk),
    .clken  (clken),
    .reset  (reset),
    .mid    (mid),
    .d_val  (d_val),
    .m_beat (m_beat)
  );

endmodule

// File: testbench/lrelu_engine_assert.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module lrelu_engine_assert (
  input  logic                  clk,
  input  logic                  clken,
  input  logic                  reset,
  input  logic                  s_valid,
  input  logic                  m_valid,
  input  lrelu_pkg::load_sel_e  load_sel
);

  // s_beat.valid history, one slot per enabled cycle
  logic [`LRELU_LATENCY-1:0] valid_hist;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_hist <= '0;
    end else if (clken) begin
      valid_hist <= {valid_hist[`LRELU_LATENCY-2:0], s_valid};
    end
  end

  a_reset_quiet: assert property (@(posedge clk) reset |=> !m_valid)
    else $error("m_beat valid after a reset cycle");

  a_sel_legal: assert property (@(posedge clk) disable iff (reset)
    load_sel inside {lrelu_pkg::SEL_D, lrelu_pkg::SEL_A, lrelu_pkg::SEL_B})
    else $error("loader state outside SEL_D, SEL_A, SEL_B");

  a_latency: assert property (@(posedge clk) disable iff (reset)
    m_valid == valid_hist[`LRELU_LATENCY-1])  // fixed pipeline depth
    else $error("m_beat valid does not follow s_beat valid by the pipeline latency");

endmodule

bind lrelu_engine lrelu_engine_assert ASSERTS (
  .clk      (clk),
  .clken    (clken),
  .reset    (reset),
  .s_valid  (s_beat.valid),
  .m_valid  (m_beat.valid),
  .load_sel (LOADER.sel)
);

// File: testbench/lrelu_engine_tb.sv
`timescale 1ns/100ps
`include "lrelu_settings.svh"

module lrelu_engine_tb;

  localparam int     UNITS   = `LRELU_UNITS;
  localparam longint OUT_MAX = 2 ** (`LRELU_OUT_W - 1) - 1;
  localparam longint OUT_MIN = -(2 ** (`LRELU_OUT_W - 1));

  logic                  clk;
  logic                  clken;
  logic                  reset;
  lrelu_pkg::cfg_beat_t  cfg;
  lrelu_pkg::in_beat_t   s_beat;
  lrelu_pkg::out_beat_t  m_beat;

  lrelu_pkg::out_beat_t  expect_q[$];  // reference beats in input order
  logic [31:0]           lfsr = 32'd85851;
  string                 test_name;
  int                    data_errs;
  int                    flag_errs;
  int                    other_errs;

  // coefficient model of what was loaded
  logic signed [`COEF_W-1:0] a_tbl [`DEPTH_1X1];
  logic signed [`COEF_W-1:0] b_tbl [`DEPTH_1X1];
  logic signed [`COEF_W-1:0] d_ref;
  int                        depth_ref;
  int                        rd_idx;

  lrelu_engine DUT (
    .clk    (clk),
    .clken  (clken),
    .reset  (reset),
    .cfg    (cfg),
    .s_beat (s_beat),
    .m_beat (m_beat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic signed [31:0] rand_word(input int bits);
    logic [31:0] raw;
    raw = lfsr_bits(bits);
    if (bits < 32 && raw[bits-1]) begin
      raw = raw | (32'hffffffff << bits);  // sign extend
    end
    return raw;
  endfunction

  // scale, bias, slope, offset, clamp
  function automatic lrelu_pkg::out_word_t ref_lane(input logic signed [31:0] x,
      input logic signed [`COEF_W-1:0] a, input logic signed [`COEF_W-1:0] b,
      input logic signed [`COEF_W-1:0] d, input logic lrelu);
    longint p;
    longint q;
    longint r;
    p = ((longint'(x) * longint'(a)) >>> `COEF_FRAC) + longint'(b);
    if (lrelu && p < 0) begin
      q = (p * `LRELU_ALPHA) >>> `ALPHA_FRAC;
    end else begin
      q = p;
    end
    r = q + longint'(d);
    if (r > OUT_MAX) r = OUT_MAX;
    if (r < OUT_MIN) r = OUT_MIN;
    return lrelu_pkg::out_word_t'(r);
  endfunction

  function automatic lrelu_pkg::in_beat_t random_beat(input int bits, input logic lrelu);
    lrelu_pkg::in_beat_t b;
    b.valid         = 1'b1;
    b.user.is_lrelu = lrelu;
    b.user.is_max   = lfsr_bits(1) != 0;
    for (int i = 0; i < UNITS; i++) begin
      b.data[i] = rand_word(bits);
    end
    return b;
  endfunction

  task automatic check_data(input lrelu_pkg::out_beat_t exp, input lrelu_pkg::out_beat_t act);
    if (act.data !== exp.data) begin
      data_errs++;
      $display("** Error %s: data expected %h actual %h", test_name, exp.data, act.data);
    end
  endtask

  task automatic check_flag(input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("** Error %s: is_max expected %b actual %b", test_name, exp, act);
    end
  endtask

  // one cycle, output taken if the edge just passed was enabled
  task automatic tick();
    lrelu_pkg::out_beat_t exp;
    @(negedge clk);
    if (clken && m_beat.valid) begin
      if (expect_q.size() == 0) begin
        other_errs++;
        $display("%s: output beat arrived with no input beat pending", test_name);
      end else begin
        exp = expect_q.pop_front();
        check_data(exp, m_beat);
        check_flag(exp.is_max, m_beat.is_max);
      end
    end
    cfg.valid    = 1'b0;
    s_beat.valid = 1'b0;
  endtask

  task automatic send_cfg(input logic mode, input logic [`COEF_W-1:0] word);
    tick();
    clken = 1'b1;
    cfg   = '{valid: 1'b1, is_1x1: mode, data: word};
  endtask

  // d first, then the a table, then the b table
  task automatic load_tables(input logic is_1x1, input logic signed [`COEF_W-1:0] d);
    int depth;
    depth = is_1x1 ? `DEPTH_1X1 : `DEPTH_3X3;
    send_cfg(is_1x1, d);
    for (int i = 0; i < depth; i++) begin
      send_cfg(is_1x1, a_tbl[i]);
    end
    for (int i = 0; i < depth; i++) begin
      send_cfg(is_1x1, b_tbl[i]);
    end
    d_ref     = d;
    depth_ref = depth;
    rd_idx    = 0;
  endtask

  task automatic send_beat(input lrelu_pkg::in_beat_t b, input bit stall);
    lrelu_pkg::out_beat_t exp;
    int                   guard;
    tick();
    s_beat       = b;
    s_beat.valid = 1'b1;
    clken        = stall ? (lfsr_bits(1) != 0) : 1'b1;
    guard        = 0;
    while (!clken) begin  // beat held until an enabled cycle
      tick();
      s_beat       = b;
      s_beat.valid = 1'b1;
      guard++;
      clken = (guard < 8) ? (lfsr_bits(1) != 0) : 1'b1;
    end
    exp.valid  = 1'b1;
    exp.is_max = b.user.is_max;
    for (int i = 0; i < UNITS; i++) begin
      exp.data[i] = ref_lane(b.data[i], a_tbl[rd_idx], b_tbl[rd_idx], d_ref, b.user.is_lrelu);
    end
    expect_q.push_back(exp);
    rd_idx = (rd_idx == depth_ref - 1) ? 0 : rd_idx + 1;
  endtask

  task automatic drain(input bit stall);
    int wait_cnt;
    wait_cnt = 0;
    while (expect_q.size() != 0 && wait_cnt < 200) begin
      tick();
      clken = stall ? (lfsr_bits(1) != 0) : 1'b1;
      wait_cnt++;
    end
    if (expect_q.size() != 0) begin
      other_errs++;
      $display("%s: timed out with %0d output beats missing", test_name, expect_q.size());
      expect_q.delete();
    end
    clken = 1'b1;
    repeat (6) tick();  // nothing extra may follow
  endtask

  task automatic identity_1x1();
    test_name = "identity_1x1";
    for (int i = 0; i < 8; i++) begin
      tick();
      if (m_beat.valid) begin
        other_errs++;
        $display("%s: output valid before any input beat", test_name);
      end
    end
    for (int i = 0; i < `DEPTH_1X1; i++) begin
      a_tbl[i] = 16'sd4096;  // 1.0
      b_tbl[i] = '0;
    end
    load_tables(1'b1, '0);
    repeat (12) send_beat(random_beat(10, 1'b0), 1'b0);
    drain(1'b0);
  endtask

  task automatic cyclic_coef();
    test_name = "cyclic_coef";
    a_tbl = '{16'sd2048, 16'sd4096, -16'sd4096, 16'sd1024, 16'sd6144, 16'sd512};
    b_tbl = '{16'sd0, 16'sd5, -16'sd7, 16'sd20, -16'sd30, 16'sd64};
    load_tables(1'b1, '0);
    repeat (14) send_beat(random_beat(8, 1'b0), 1'b0);  // wraps past entry 5
    drain(1'b0);
  endtask

  task automatic lrelu_d_max();
    lrelu_pkg::in_beat_t b;
    test_name = "lrelu_d_max";
    for (int i = 0; i < `DEPTH_1X1; i++) begin
      a_tbl[i] = 16'sd4096;
      b_tbl[i] = '0;
    end
    load_tables(1'b1, 16'sd10);
    b = random_beat(10, 1'b1);
    b.data[0] = -32'sd300;
    b.data[1] = -32'sd100;
    b.data[2] = -32'sd1;
    b.data[3] = 32'sd0;
    b.data[4] = 32'sd117;
    b.data[5] = 32'sd118;  // lands on the clamp with d
    send_beat(b, 1'b0);
    repeat (6) send_beat(random_beat(10, 1'b1), 1'b0);
    repeat (2) send_beat(random_beat(10, 1'b0), 1'b0);
    drain(1'b0);
  endtask

  task automatic mode_3x3_reload();
    test_name = "mode_3x3_reload";
    a_tbl[0] = 16'sd8192;
    a_tbl[1] = 16'sd2048;
    b_tbl[0] = 16'sd3;
    b_tbl[1] = -16'sd3;
    load_tables(1'b0, -16'sd5);
    repeat (5) send_beat(random_beat(8, 1'b0), 1'b0);  // leaves the index at 1
    drain(1'b0);
    a_tbl[0] = 16'sd4096;
    a_tbl[1] = -16'sd2048;
    b_tbl[0] = 16'sd0;
    b_tbl[1] = 16'sd1;
    load_tables(1'b0, '0);
    repeat (4) send_beat(random_beat(8, 1'b1), 1'b0);
    drain(1'b0);
  endtask

  task automatic stall_pipeline();
    lrelu_pkg::in_beat_t b;
    test_name = "stall_pipeline";
    a_tbl = '{16'sd32767, 16'sd4096, 16'sh8000, 16'sd20000, 16'sd4096, 16'sd1};
    b_tbl = '{16'sd100, -16'sd100, 16'sd0, 16'sd32767, 16'sh8000, 16'sd0};
    load_tables(1'b1, 16'sd3);
    b = random_beat(32, 1'b0);
    b.data[0] = 32'sh7fffffff;
    b.data[1] = 32'sh80000000;  // both rails with a near 8.0
    send_beat(b, 1'b1);
    repeat (16) send_beat(random_beat(32, lfsr_bits(1) != 0), 1'b1);
    drain(1'b1);
  endtask

  initial begin
    clken      = 1'b1;
    reset      = 1'b1;
    cfg        = '0;
    s_beat     = '0;
    data_errs  = 0;
    flag_errs  = 0;
    other_errs = 0;
    d_ref      = '0;
    depth_ref  = `DEPTH_3X3;
    rd_idx     = 0;
    test_name  = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    identity_1x1();
    cyclic_coef();
    lrelu_d_max();
    mode_3x3_reload();
    stall_pipeline();
    $display("data errors %0d, flag errors %0d, other errors %0d",
             data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+verilog
verilog/lrelu_pkg.sv
verilog/cyclic_table.sv
verilog/coef_loader.sv
verilog/affine_stage.sv
verilog/lrelu_stage.sv
verilog/lrelu_engine.sv
testbench/lrelu_engine_assert.sv
testbench/lrelu_engine_tb.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, and pass only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module lrelu_engine_tb -o lrelu_sim \
  && out=$(./obj_dir/lrelu_sim) \
  && echo "$out" \
  && echo "$out" | grep -qF '*** TEST PASSED ***' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
